// File: logic/fir_pkg.sv
package fir_pkg;

    // --------------------
    // Widths and sizes
    // --------------------

    // Sample, coefficient and register data
    localparam int data_width = 32;
    // Register port address
    localparam int addr_width = 12;
    localparam int tap_num    = 11;
    // Enough for a RAM slot or a count up to tap_num
    localparam int idx_width  = 4;

    // --------------------
    // Register map
    // --------------------

    localparam logic [addr_width-1:0] ap_ctrl_addr  = 12'h000;
    // Coefficient k at tap_base_addr + 4k
    localparam logic [addr_width-1:0] tap_base_addr = 12'h020;

    // Control register bit positions
    localparam int ap_start_bit = 0;
    localparam int ap_done_bit  = 1;
    localparam int ap_idle_bit  = 2;

    // --------------------
    // Types
    // --------------------

    typedef logic [data_width-1:0] coef_t;
    typedef logic [data_width-1:0] sample_t;
    typedef logic [idx_width-1:0]  ram_idx_t;

    // Run sequencer states
    typedef enum logic [1:0] {
        fir_wait,
        fir_idle,
        fir_proc,
        fir_done
    } fir_state_e;

endpackage

// File: logic/fir_ctrl_if.sv
interface fir_ctrl_if import fir_pkg::*; ();

    // Current sequencer state
    fir_state_e state;

    // Strobes from the sequencer
    // Leaving fir_wait
    logic run_start;
    // Input handshake done
    logic sample_take;
    // Level, next state is fir_proc
    logic proc_next;
    // fir_proc to fir_done
    logic last_proc;
    // fir_done to fir_wait
    logic run_end;

    // Back from the counter, last process cycle reached
    logic proc_last_cnt;

    modport fsm (
        output state, run_start, sample_take, proc_next, last_proc, run_end,
        input  proc_last_cnt
    );

    modport counter (
        input  state, run_start, sample_take, proc_next, last_proc,
        output proc_last_cnt
    );

    modport mac (input state);

    modport regs (input run_start, run_end, proc_next);

endinterface

// File: logic/cfg_regs.sv
module cfg_regs import fir_pkg::*; (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  awvalid,
    input  logic [addr_width-1:0] awaddr,
    output logic                  wready,
    input  logic                  wvalid,
    input  logic [data_width-1:0] wdata,
    output logic                  arready,
    input  logic                  arvalid,
    input  logic [addr_width-1:0] araddr,
    output logic                  rvalid,
    output logic [data_width-1:0] rdata,
    input  logic                  rready,
    input  ram_idx_t              tap_idx,
    input  coef_t                 coef_rd,
    fir_ctrl_if.regs              ctrl,
    output logic                  ap_start,
    output logic                  coef_we,
    output ram_idx_t              coef_addr,
    output coef_t                 coef_wr,
    output logic                  h0_we
);

    // Shared by both ports, write never visits port_wait
    typedef enum logic [1:0] {port_idle, port_addr, port_wait, port_data} port_state_e;

    port_state_e           wr_state;
    port_state_e           rd_state;
    logic [addr_width-1:0] wr_addr_q;
    logic [addr_width-1:0] rd_addr_q;
    logic                  ap_done;
    logic                  ap_idle;
    logic                  wr_fire;
    logic                  wr_tap;

    // Word aligned and inside the coefficient window
    function automatic logic is_tap(input logic [addr_width-1:0] a);
        return (a >= tap_base_addr) && (a < tap_base_addr + 4 * tap_num) && (a[1:0] == 2'b00);
    endfunction

    function automatic ram_idx_t tap_index(input logic [addr_width-1:0] a);
        logic [addr_width-1:0] off;
        off = a - tap_base_addr;
        return off[idx_width+1:2];
    endfunction

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_state <= port_idle;
        end else begin
            case (wr_state)
                port_idle: wr_state <= port_addr;
                port_addr: if (awvalid) wr_state <= port_data;
                port_data: if (wvalid) wr_state <= port_idle;
                default:   wr_state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_state == port_addr && awvalid) begin
            wr_addr_q <= awaddr;
        end
    end

    assign wready  = (wr_state == port_data);
    assign wr_fire = wready && wvalid;
    assign wr_tap  = is_tap(wr_addr_q);
    // No coefficient updates while a run is active
    assign coef_we = wr_fire && wr_tap && ap_idle;
    assign h0_we   = coef_we && (tap_index(wr_addr_q) == '0);
    assign coef_wr = wdata;

    // --------------------
    // Read port
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            rd_state <= port_idle;
        end else begin
            case (rd_state)
                port_idle: rd_state <= port_addr;
                port_addr: if (arvalid) rd_state <= port_wait;
                // RAM address goes out here
                port_wait: rd_state <= port_data;
                port_data: if (rready) rd_state <= port_idle;
                default:   rd_state <= port_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (arready && arvalid) begin
            rd_addr_q <= araddr;
        end
    end

    assign arready = (rd_state == port_addr);
    assign rvalid  = (rd_state == port_data);

    always_comb begin
        rdata = '0;
        if (rd_addr_q == ap_ctrl_addr) begin
            rdata[ap_start_bit] = ap_start;
            rdata[ap_done_bit]  = ap_done;
            rdata[ap_idle_bit]  = ap_idle;
        end else if (is_tap(rd_addr_q)) begin
            rdata = coef_rd;
        end
    end

    // Sequencer first, then a firing tap write, else the held read
    always_comb begin
        if (ctrl.proc_next) begin
            coef_addr = tap_idx;
        end else if (wr_fire && wr_tap) begin
            coef_addr = tap_index(wr_addr_q);
        end else begin
            coef_addr = tap_index(rd_addr_q);
        end
    end

    // --------------------
    // Control flags
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            // Start is consumed as the run begins
            if (ctrl.run_start) begin
                ap_start <= 1'b0;
            end else if (wr_fire && wr_addr_q == ap_ctrl_addr) begin
                ap_start <= wdata[ap_start_bit];
            end
            // Done is read-to-clear
            if (ctrl.run_end) begin
                ap_done <= 1'b1;
            end else if (rvalid && rready && rd_addr_q == ap_ctrl_addr) begin
                ap_done <= 1'b0;
            end
            if (ctrl.run_start) begin
                ap_idle <= 1'b0;
            end else if (ctrl.run_end) begin
                ap_idle <= 1'b1;
            end
        end
    end

    // Pending read data must not lose its RAM address to a tap write
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid |-> !(wr_fire && wr_tap));

endmodule

// File: logic/fir_ctrl_fsm.sv
module fir_ctrl_fsm import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  logic     ap_start,
    input  logic     ss_tvalid,
    input  logic     ss_tlast,
    output logic     ss_tready,
    input  logic     sm_tready,
    output logic     sm_tvalid,
    output logic     sm_tlast,
    fir_ctrl_if.fsm  ctrl
);

    fir_state_e state_q;
    fir_state_e state_d;
    // Run ends after the current output
    logic       tlast_q;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state_q <= fir_wait;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            fir_wait: if (ap_start) state_d = fir_idle;
            fir_idle: if (ss_tvalid) state_d = fir_proc;
            fir_proc: if (ctrl.proc_last_cnt) state_d = fir_done;
            // Output taken, back for more or finish the run
            fir_done: if (sm_tready) state_d = tlast_q ? fir_wait : fir_idle;
            default:  state_d = fir_wait;
        endcase
    end

    // Latch tlast at the input handshake
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            tlast_q <= 1'b0;
        end else if (ctrl.run_start) begin
            tlast_q <= 1'b0;
        end else if (ctrl.sample_take && ss_tlast) begin
            tlast_q <= 1'b1;
        end
    end

    // --------------------
    // Strobes and streams
    // --------------------
    assign ctrl.state       = state_q;
    assign ctrl.run_start   = (state_q == fir_wait) && ap_start;
    assign ctrl.sample_take = (state_q == fir_idle) && ss_tvalid;
    assign ctrl.proc_next   = (state_d == fir_proc);
    assign ctrl.last_proc   = (state_q == fir_proc) && ctrl.proc_last_cnt;
    assign ctrl.run_end     = (state_q == fir_done) && sm_tready && tlast_q;

    assign ss_tready = (state_q == fir_idle);
    assign sm_tvalid = (state_q == fir_done);
    assign sm_tlast  = sm_tvalid && tlast_q;

    // Output held under back-pressure
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid);

endmodule

// File: logic/fir_tap_counter.sv
module fir_tap_counter import fir_pkg::*; (
    input  logic        axis_clk,
    input  logic        axis_rst_n,
    fir_ctrl_if.counter ctrl,
    output ram_idx_t    tap_idx,
    output ram_idx_t    sample_addr,
    output logic        sample_we
);

    ram_idx_t sample_cnt;
    ram_idx_t proc_cnt;
    ram_idx_t wr_ptr;
    ram_idx_t rd_ptr;

    // Step one slot down, wrapping below zero
    function automatic ram_idx_t dec_wrap(input ram_idx_t i);
        return (i == '0) ? ram_idx_t'(tap_num - 1) : i - 1'b1;
    endfunction

    // --------------------
    // Counts
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            sample_cnt <= '0;
            proc_cnt   <= '0;
            tap_idx    <= ram_idx_t'(1);
        end else begin
            // Saturates once the history is full
            if (ctrl.run_start) begin
                sample_cnt <= '0;
            end else if (ctrl.sample_take && sample_cnt < tap_num) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            proc_cnt <= (ctrl.state == fir_proc) ? proc_cnt + 1'b1 : '0;
            // h0 comes from the MAC buffer, so start at h1
            if (!ctrl.proc_next) begin
                tap_idx <= ram_idx_t'(1);
            end else if (tap_idx != tap_num - 1) begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

    assign ctrl.proc_last_cnt = (proc_cnt == sample_cnt - 1'b1);

    // --------------------
    // Sample slots
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= ram_idx_t'(tap_num - 1);
        end else if (ctrl.run_start) begin
            wr_ptr <= '0;
            rd_ptr <= ram_idx_t'(tap_num - 1);
        end else begin
            if (ctrl.last_proc) begin
                wr_ptr <= (wr_ptr == tap_num - 1) ? '0 : wr_ptr + 1'b1;
            end
            // Newest stored sample first, then walk back in time
            if (ctrl.state == fir_done) begin
                rd_ptr <= dec_wrap(wr_ptr);
            end else if (ctrl.proc_next) begin
                rd_ptr <= dec_wrap(rd_ptr);
            end
        end
    end

    assign sample_we   = ctrl.last_proc;
    assign sample_addr = ctrl.last_proc ? wr_ptr : rd_ptr;

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (tap_idx < tap_num) && (sample_addr < tap_num));

endmodule

// File: logic/fir_ram.sv
module fir_ram import fir_pkg::*; #(
    parameter type payload_t = coef_t
) (
    input  logic     axis_clk,
    input  logic     we,
    input  ram_idx_t addr,
    input  payload_t wr,
    output payload_t rd
);

    payload_t mem [tap_num];

    // Single port, old data on a write cycle
    always_ff @(posedge axis_clk) begin
        if (we) begin
            mem[addr] <= wr;
        end
        rd <= mem[addr];
    end

    // Writers decode addresses before they get here
    assert property (@(posedge axis_clk) we |-> addr < tap_num);

endmodule

// File: logic/fir_mac.sv
module fir_mac import fir_pkg::*; (
    input  logic     axis_clk,
    input  logic     axis_rst_n,
    input  sample_t  ss_tdata,
    input  logic     h0_we,
    input  coef_t    h0_wr,
    input  coef_t    coef_rd,
    input  sample_t  sample_rd,
    fir_ctrl_if.mac  ctrl,
    output sample_t  sm_tdata,
    output sample_t  sample_wr
);

    // Newest sample, stored to the RAM at the end of processing
    sample_t               x_buf;
    // Copy of h0 so the first product needs no RAM read
    coef_t                 h0_buf;
    logic [data_width-1:0] prod_q;
    logic [data_width-1:0] acc_q;

    always_ff @(posedge axis_clk) begin
        if (ctrl.state == fir_idle) begin
            x_buf <= ss_tdata;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (h0_we) begin
            h0_buf <= h0_wr;
        end
    end

    // --------------------
    // Multiply, low word kept
    // --------------------
    always_ff @(posedge axis_clk) begin
        if (ctrl.state == fir_idle) begin
            prod_q <= ss_tdata * h0_buf;
        end else begin
            prod_q <= sample_rd * coef_rd;
        end
    end

    // Accumulate one product per process cycle
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            acc_q <= '0;
        end else begin
            case (ctrl.state)
                fir_proc: acc_q <= acc_q + prod_q;
                // Held for the output handshake
                fir_done: acc_q <= acc_q;
                default:  acc_q <= '0;
            endcase
        end
    end

    assign sm_tdata  = acc_q;
    assign sample_wr = x_buf;

endmodule

// File: logic/fir_top.sv
module fir_top import fir_pkg::*; (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    // Register write
    input  logic                  awvalid,
    input  logic [addr_width-1:0] awaddr,
    output logic                  wready,
    input  logic                  wvalid,
    input  logic [data_width-1:0] wdata,
    // Register read
    input  logic                  arvalid,
    input  logic [addr_width-1:0] araddr,
    output logic                  arready,
    output logic                  rvalid,
    output logic [data_width-1:0] rdata,
    input  logic                  rready,
    // Input samples
    input  logic                  ss_tvalid,
    input  sample_t               ss_tdata,
    input  logic                  ss_tlast,
    output logic                  ss_tready,
    // Output samples
    output logic                  sm_tvalid,
    output sample_t               sm_tdata,
    output logic                  sm_tlast,
    input  logic                  sm_tready
);

    logic     ap_start;
    logic     coef_we;
    ram_idx_t coef_addr;
    coef_t    coef_wr;
    coef_t    coef_rd;
    logic     h0_we;
    ram_idx_t tap_idx;
    logic     sample_we;
    ram_idx_t sample_addr;
    sample_t  sample_wr;
    sample_t  sample_rd;

    fir_ctrl_if ctrl_if ();

    // --------------------
    // Control
    // --------------------
    cfg_regs u_cfg_regs (
        .axis_clk, .axis_rst_n, .awvalid, .awaddr, .wready, .wvalid, .wdata,
        .arready, .arvalid, .araddr, .rvalid, .rdata, .rready,
        .tap_idx, .coef_rd, .ctrl(ctrl_if), .ap_start,
        .coef_we, .coef_addr, .coef_wr, .h0_we
    );

    fir_ctrl_fsm u_fir_ctrl_fsm (
        .axis_clk, .axis_rst_n, .ap_start, .ss_tvalid, .ss_tlast, .ss_tready,
        .sm_tready, .sm_tvalid, .sm_tlast, .ctrl(ctrl_if)
    );

    fir_tap_counter u_fir_tap_counter (
        .axis_clk, .axis_rst_n, .ctrl(ctrl_if), .tap_idx, .sample_addr, .sample_we
    );

    // --------------------
    // Datapath
    // --------------------
    fir_ram #(.payload_t(coef_t)) coef_ram (
        .axis_clk, .we(coef_we), .addr(coef_addr), .wr(coef_wr), .rd(coef_rd)
    );

    fir_ram #(.payload_t(sample_t)) sample_ram (
        .axis_clk, .we(sample_we), .addr(sample_addr), .wr(sample_wr), .rd(sample_rd)
    );

    fir_mac u_fir_mac (
        .axis_clk, .axis_rst_n, .ss_tdata, .h0_we, .h0_wr(coef_wr), .coef_rd,
        .sample_rd, .ctrl(ctrl_if), .sm_tdata, .sample_wr
    );

endmodule

// File: sim/tb_fir.sv
module tb_fir import fir_pkg::*; ();

    // Longest run in samples
    localparam int max_samples    = 32;
    localparam int drive_delay    = 2;
    localparam int timeout_cycles = 200;
    localparam logic [31:0] lfsr_seed = 32'h6b5a_05ee;

    logic                  axis_clk;
    logic                  axis_rst_n;
    logic                  awvalid;
    logic [addr_width-1:0] awaddr;
    logic                  wready;
    logic                  wvalid;
    logic [data_width-1:0] wdata;
    logic                  arvalid;
    logic [addr_width-1:0] araddr;
    logic                  arready;
    logic                  rvalid;
    logic [data_width-1:0] rdata;
    logic                  rready;
    logic                  ss_tvalid;
    sample_t               ss_tdata;
    logic                  ss_tlast;
    logic                  ss_tready;
    logic                  sm_tvalid;
    sample_t               sm_tdata;
    logic                  sm_tlast;
    logic                  sm_tready;

    // Expected-value state shared with the output checker
    coef_t       coef_arr [tap_num];
    sample_t     samp_arr [max_samples];
    int          run_len;
    int          out_idx;
    int          runs_done;
    int          outputs_seen;
    int          stall_cycles;
    logic [31:0] lfsr_q;

    fir_top DUT (
        .axis_clk, .axis_rst_n, .awvalid, .awaddr, .wready, .wvalid, .wdata,
        .arvalid, .araddr, .arready, .rvalid, .rdata, .rready,
        .ss_tvalid, .ss_tdata, .ss_tlast, .ss_tready,
        .sm_tvalid, .sm_tdata, .sm_tlast, .sm_tready
    );

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    // --------------------
    // Random source
    // --------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // --------------------
    // Reference model
    // --------------------

    // y[n] = sum h[k] * x[n-k], k up to min(n, 10), low 32 bits
    function automatic logic [31:0] fir_ref(input coef_t h [tap_num],
                                            input sample_t x [max_samples],
                                            input int n);
        logic [31:0] acc;
        int          kmax;
        acc  = '0;
        kmax = (n < tap_num - 1) ? n : tap_num - 1;
        for (int k = 0; k <= kmax; k++) begin
            acc = acc + h[k] * x[n - k];
        end
        return acc;
    endfunction

    // --------------------
    // Error reporting
    // --------------------

    task automatic abort_test(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // --------------------
    // Register port
    // --------------------

    // All bus tasks start and end a drive_delay after a rising edge
    task automatic write_reg(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] data);
        int waited;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        waited  = 0;
        while (!wready) begin
            @(posedge axis_clk);
            #drive_delay;
            waited++;
            if (waited > timeout_cycles) abort_test("register write never reached wready");
        end
        // Write lands on this edge
        @(posedge axis_clk);
        #drive_delay;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input logic [addr_width-1:0] addr,
                            output logic [data_width-1:0] data);
        int waited;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        while (!arready) begin
            @(posedge axis_clk);
            #drive_delay;
            waited++;
            if (waited > timeout_cycles) abort_test("read address never accepted");
        end
        @(posedge axis_clk);
        #drive_delay;
        arvalid = 1'b0;
        // Random rready stalls while data is pending
        rready = rand_bits(1);
        waited = 0;
        while (!(rvalid && rready)) begin
            @(posedge axis_clk);
            #drive_delay;
            rready = rand_bits(1);
            waited++;
            if (waited > timeout_cycles) abort_test("read data never returned");
        end
        data = rdata;
        @(posedge axis_clk);
        #drive_delay;
        rready = 1'b0;
    endtask

    task automatic program_coefs();
        logic [data_width-1:0] rd;
        for (int k = 0; k < tap_num; k++) begin
            coef_arr[k] = rand_bits(32);
            write_reg(tap_base_addr + 4 * k, coef_arr[k]);
        end
        for (int k = 0; k < tap_num; k++) begin
            read_reg(tap_base_addr + 4 * k, rd);
            expect_equal($sformatf("rdata of tap %0d", k), rd, coef_arr[k]);
        end
    endtask

    // --------------------
    // Streams
    // --------------------

    task automatic send_sample(input sample_t data, input logic last);
        int waited;
        ss_tdata  = data;
        ss_tlast  = last;
        ss_tvalid = 1'b1;
        waited    = 0;
        while (!ss_tready) begin
            @(posedge axis_clk);
            #drive_delay;
            waited++;
            if (waited > timeout_cycles) abort_test("input sample never accepted");
        end
        @(posedge axis_clk);
        #drive_delay;
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    // Random sm_tready each cycle until the output is taken
    task automatic take_output();
        int waited;
        waited    = 0;
        sm_tready = rand_bits(1);
        while (!(sm_tvalid && sm_tready)) begin
            @(posedge axis_clk);
            #drive_delay;
            sm_tready = rand_bits(1);
            waited++;
            if (waited > timeout_cycles) abort_test("output sample never arrived");
        end
        @(posedge axis_clk);
        #drive_delay;
        sm_tready = 1'b0;
    endtask

    task automatic run_stream(input int n_samples);
        int base_runs;
        int waited;
        run_len   = n_samples;
        base_runs = runs_done;
        write_reg(ap_ctrl_addr, 32'h1);
        // One sample in flight at a time
        for (int i = 0; i < n_samples; i++) begin
            samp_arr[i] = rand_bits(32);
            send_sample(samp_arr[i], i == n_samples - 1);
            take_output();
        end
        waited = 0;
        while (runs_done != base_runs + 1) begin
            @(posedge axis_clk);
            #drive_delay;
            waited++;
            if (waited > timeout_cycles) abort_test("run end never seen by the checker");
        end
    endtask

    // --------------------
    // Output checker
    // --------------------
    initial begin : output_checker
        sample_t expected;
        logic    held_valid;
        sample_t held_data;
        held_valid = 1'b0;
        held_data  = '0;
        // Mid-cycle sampling, all signals settled
        forever begin
            @(negedge axis_clk);
            if (axis_rst_n) begin
                if (held_valid) begin
                    expect_equal("sm_tvalid under back-pressure", sm_tvalid, 1);
                    expect_equal("sm_tdata under back-pressure", sm_tdata, held_data);
                end
                assert (!(sm_tlast && !sm_tvalid)) else begin
                    abort_test("sm_tlast high without sm_tvalid");
                end
                if (sm_tvalid && sm_tready) begin
                    expected = fir_ref(coef_arr, samp_arr, out_idx);
                    expect_equal($sformatf("sm_tdata[%0d]", out_idx), sm_tdata, expected);
                    expect_equal("sm_tlast", sm_tlast, out_idx == run_len - 1);
                    outputs_seen++;
                    out_idx++;
                    if (out_idx == run_len) begin
                        out_idx = 0;
                        runs_done++;
                    end
                end
                held_valid = sm_tvalid && !sm_tready;
                held_data  = sm_tdata;
                if (held_valid) stall_cycles++;
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        logic [data_width-1:0] rd;
        axis_rst_n    = 1'b0;
        awvalid       = 1'b0;
        awaddr        = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        arvalid       = 1'b0;
        araddr        = '0;
        rready        = 1'b0;
        ss_tvalid     = 1'b0;
        ss_tdata      = '0;
        ss_tlast      = 1'b0;
        sm_tready     = 1'b0;
        lfsr_q        = lfsr_seed;
        run_len       = 0;
        out_idx       = 0;
        runs_done     = 0;
        outputs_seen  = 0;
        stall_cycles  = 0;
        for (int k = 0; k < tap_num; k++) coef_arr[k] = '0;
        for (int i = 0; i < max_samples; i++) samp_arr[i] = '0;

        repeat (8) @(posedge axis_clk);
        #drive_delay;
        // Handshake outputs quiet in reset
        expect_equal("wready in reset", wready, 0);
        expect_equal("arready in reset", arready, 0);
        expect_equal("rvalid in reset", rvalid, 0);
        expect_equal("ss_tready in reset", ss_tready, 0);
        expect_equal("sm_tvalid in reset", sm_tvalid, 0);
        expect_equal("sm_tlast in reset", sm_tlast, 0);
        axis_rst_n = 1'b1;

        // Idle only after reset
        read_reg(ap_ctrl_addr, rd);
        expect_equal("ap_ctrl after reset", rd, 32'h4);
        expect_equal("ss_tready after reset", ss_tready, 0);
        expect_equal("sm_tvalid after reset", sm_tvalid, 0);

        // Coefficients and unmapped reads
        program_coefs();
        read_reg(12'h010, rd);
        expect_equal("rdata of 0x010", rd, 32'h0);
        read_reg(tap_base_addr + 4 * tap_num, rd);
        expect_equal("rdata past last tap", rd, 32'h0);

        // First run, partial then full history
        run_stream(30);
        read_reg(ap_ctrl_addr, rd);
        expect_equal("ap_ctrl after run 1", rd, 32'h6);
        read_reg(ap_ctrl_addr, rd);
        expect_equal("ap_ctrl second read after run 1", rd, 32'h4);

        // Second run, history starts empty again
        program_coefs();
        run_stream(15);
        read_reg(ap_ctrl_addr, rd);
        expect_equal("ap_ctrl after run 2", rd, 32'h6);
        read_reg(ap_ctrl_addr, rd);
        expect_equal("ap_ctrl second read after run 2", rd, 32'h4);

        expect_equal("output count", outputs_seen, 45);
        assert (stall_cycles > 0) else begin
            abort_test("sm_tready never stalled a valid output");
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// File: sim.f
logic/fir_pkg.sv
logic/fir_ctrl_if.sv
logic/cfg_regs.sv
logic/fir_ctrl_fsm.sv
logic/fir_tap_counter.sv
logic/fir_ram.sv
logic/fir_mac.sv
logic/fir_top.sv
sim/tb_fir.sv

// File: Bender.yml
package:
  name: fir_filter

sources:
  - files:
      - logic/fir_pkg.sv
      - logic/fir_ctrl_if.sv
      - logic/cfg_regs.sv
      - logic/fir_ctrl_fsm.sv
      - logic/fir_tap_counter.sv
      - logic/fir_ram.sv
      - logic/fir_mac.sv
      - logic/fir_top.sv
  - target: simulation
    files:
      - sim/tb_fir.sv
